// File: nd_io_pkg.sv
// ##########################################################################
// Shared bus types and IOC bit map for the I/O register block
// IDB is 16 bits wide; INR, IOC load data and IOC contents use the low byte
// ALD defaults describe a version D board, straps 9, 8 and 6 fitted
// A fitted strap reads as 0, an open one as 1
// ##########################################################################
`default_nettype none

package nd_io_pkg;

   // Internal data bus
   typedef logic [15:0] idb_word_t;      // Full IDB word
   typedef logic [7:0]  idb_byte_t;      // Low half of IDB

   // ALD word fields
   typedef logic [3:0]  ald_switch_t;    // Boot switch setting
   typedef logic [2:0]  print_no_t;      // Board print version
   typedef logic [4:0]  straps_t;        // Strap 9 at MSB, strap 5 at LSB

   // General control bits of IOC
   localparam int IOC_BIT_IOC0    = 0;   // Gates level 13 with ioc3
   localparam int IOC_BIT_IOC1    = 1;   // Gates level 12 (console input)
   localparam int IOC_BIT_IOC2    = 2;   // Gates level 10 (transmitter)
   localparam int IOC_BIT_IOC3    = 3;   // Gates level 13 with ioc0

   // Panel and console bits of IOC
   localparam int IOC_BIT_GREEN_N = 4;   // Green lamp
   localparam int IOC_BIT_RED_N   = 5;   // Red lamp, also emergency clear
   localparam int IOC_BIT_SCONS_N = 6;   // Console select
   localparam int IOC_BIT_RESET   = 7;   // Stored, no output on the board

   // Default ALD field values

   // Boot from HDLC
   localparam ald_switch_t ALD_SWITCH_DEF = 4'b0101;

   // Print 3, version D
   localparam print_no_t PRINT_NO_DEF = 3'b011;

   // ECO strap set
   localparam straps_t STRAPS_DEF = 5'b00101;

   // Upper ALD bits always read high
   localparam logic [2:0] ALD_TOP_ONES = 3'b111;

endpackage

`default_nettype wire

// File: io_sync.sv
// ##########################################################################
// Two flop synchronizer for inputs that are asynchronous to clk
// Delay is two clock edges; no glitch filtering on multi-bit payloads
// Both stages reset to RESET_VAL so idle levels hold during reset
// ##########################################################################
`default_nettype none

module io_sync #(
   parameter type  sig_t     = logic,  // Payload, single bit or vector
   parameter sig_t RESET_VAL = '0      // Idle value of the payload
) (
   input  logic clk,
   input  logic arst_n,
   input  sig_t d,                     // Asynchronous input
   output sig_t q                      // Synchronized to clk
);

   sig_t meta_q;                       // First stage, may go metastable

   // Each bit gets its own pair of flops
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         meta_q <= RESET_VAL;
         q      <= RESET_VAL;          // Keeps active-low lines idle
      end else begin
         meta_q <= d;                  // Capture
         q      <= meta_q;             // Settle
      end
   end

endmodule

`default_nettype wire

// File: ioc_reg.sv
// ##########################################################################
// IOC control register with panel lamps, console select and IRQ gates
// Load on any clk edge with sioc_n low; clear_n low wins over sioc_n
// tbmt_n and da_n must already be synchronous to clk
// Bit 7 is held but drives nothing, as on the board
// ##########################################################################
`default_nettype none

module ioc_reg (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 clear_n,    // Synchronous clear
   input  logic                 sioc_n,     // Write strobe
   input  nd_io_pkg::idb_byte_t ioc_d,      // Merged bus byte
   input  logic                 tbmt_n,     // UART transmitter empty
   input  logic                 da_n,       // UART data available
   output logic                 bint10_n,   // Level 10 request
   output logic                 bint12_n,   // Level 12 request
   output logic                 bint13_n,   // Level 13 request
   output logic                 console_n,
   output logic                 emcl_n,
   output logic [1:0]           io_led      // 0 red, 1 green
);

   nd_io_pkg::idb_byte_t ioc_q;             // Register contents

   logic tbmt;                              // Active-high status
   logic da;
   logic scons_n;                           // Console select bit
   logic console_io;                        // Console owns input

   // Register with clear over load
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ioc_q <= '0;
      end else if (!clear_n) begin
         ioc_q <= '0;                       // Clear takes priority
      end else if (!sioc_n) begin
         ioc_q <= ioc_d;                    // Load from bus
      end
   end

   // UART status to active high
   assign tbmt = ~tbmt_n;
   assign da   = ~da_n;

   assign scons_n    = ioc_q[nd_io_pkg::IOC_BIT_SCONS_N];
   assign console_io = scons_n & ioc_q[nd_io_pkg::IOC_BIT_IOC1];

   // Level 13 needs both general bits
   assign bint13_n = ~(ioc_q[nd_io_pkg::IOC_BIT_IOC3] & ioc_q[nd_io_pkg::IOC_BIT_IOC0]);

   // Level 10 when transmitter ready
   assign bint10_n = ~(ioc_q[nd_io_pkg::IOC_BIT_IOC2] & tbmt);

   // Level 12 on received character
   assign bint12_n = ~(console_io & da);

   // Panel and console lines
   assign console_n = scons_n;
   assign emcl_n    = ioc_q[nd_io_pkg::IOC_BIT_RED_N];      // Shares the red lamp bit
   assign io_led[0] = ioc_q[nd_io_pkg::IOC_BIT_RED_N];      // Red
   assign io_led[1] = ioc_q[nd_io_pkg::IOC_BIT_GREEN_N];    // Green

endmodule

`default_nettype wire

// File: io_read_path.sv
// ##########################################################################
// Read side of the register sheet: ALD word, INR gate and bus merge
// Purely combinational; strobes are active low and synchronous to clk
// Undriven bits read as zero, sources are OR-merged like the wired bus
// Strap order on IDB 8..11 is reversed, as wired on the board
// ##########################################################################
`default_nettype none

module io_read_path #(
   parameter nd_io_pkg::ald_switch_t ALD_SWITCH = nd_io_pkg::ALD_SWITCH_DEF,
   parameter nd_io_pkg::print_no_t   PRINT_NO   = nd_io_pkg::PRINT_NO_DEF,
   parameter nd_io_pkg::straps_t     STRAPS     = nd_io_pkg::STRAPS_DEF
) (
   input  logic                 ald_en_n,   // ALD read strobe
   input  logic                 inr_en_n,   // INR read strobe
   input  logic                 cx_n,       // Synchronized CX line
   input  nd_io_pkg::idb_byte_t inr,        // Synchronized INR
   input  nd_io_pkg::idb_byte_t idb_in,     // Byte driven by the CPU
   output nd_io_pkg::idb_word_t idb_out,    // Merged read data
   output nd_io_pkg::idb_byte_t ioc_d       // IOC load data
);

   nd_io_pkg::idb_word_t ald_word;          // Full ALD word
   nd_io_pkg::idb_word_t ald_bus;           // Gated ALD
   nd_io_pkg::idb_byte_t inr_bus;           // Gated INR

   // ALD word assembly, MSB first
   assign ald_word = {
      nd_io_pkg::ALD_TOP_ONES,              // Bits 15..13
      STRAPS[0],                            // Bit 12, strap 5
      STRAPS[1],                            // Bit 11, strap 6
      STRAPS[2],                            // Bit 10, strap 7
      STRAPS[3],                            // Bit 9, strap 8
      STRAPS[4],                            // Bit 8, strap 9
      cx_n,                                 // Bit 7
      PRINT_NO,                             // Bits 6..4
      ALD_SWITCH                            // Bits 3..0
   };

   // Source gates
   assign ald_bus = ald_en_n ? '0 : ald_word;
   assign inr_bus = inr_en_n ? '0 : inr;    // Low byte only

   // Wired-OR bus, INR shares the low byte with ALD
   assign idb_out = ald_bus | {8'h00, inr_bus};

   // Register sees whatever is on the low byte
   assign ioc_d = idb_in | idb_out[7:0];

endmodule

`default_nettype wire

// File: io_reg_top.sv
// ##########################################################################
// I/O register sheet top: input synchronizers, IOC register, read path
// tbmt_n, da_n, cx_n and inr are asynchronous and take 2 clk edges
// Strobes sioc_n, clear_n, traald_n and rinr_n must be synchronous to clk
// No back-pressure; every cycle is accepted
// ##########################################################################
`default_nettype none

module io_reg_top #(
   parameter nd_io_pkg::ald_switch_t ALD_SWITCH = nd_io_pkg::ALD_SWITCH_DEF,
   parameter nd_io_pkg::print_no_t   PRINT_NO   = nd_io_pkg::PRINT_NO_DEF,
   parameter nd_io_pkg::straps_t     STRAPS     = nd_io_pkg::STRAPS_DEF
) (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 clear_n,    // IOC clear
   input  logic                 sioc_n,     // IOC write
   input  logic                 traald_n,   // ALD read
   input  logic                 rinr_n,     // INR read
   input  logic                 cx_n,       // Async
   input  logic                 da_n,       // Async, UART
   input  logic                 tbmt_n,     // Async, UART
   input  nd_io_pkg::idb_byte_t inr,        // Async input register data
   input  nd_io_pkg::idb_byte_t idb_in,
   output nd_io_pkg::idb_word_t idb_out,
   output logic                 bint10_n,
   output logic                 bint12_n,
   output logic                 bint13_n,
   output logic                 console_n,
   output logic                 emcl_n,
   output logic [1:0]           io_led      // 0 red, 1 green
);

   logic                 cx_n_s;            // Synchronized status
   logic                 da_n_s;
   logic                 tbmt_n_s;
   nd_io_pkg::idb_byte_t inr_s;             // Synchronized INR
   nd_io_pkg::idb_byte_t ioc_d;             // Bus byte to IOC

   // Status lines idle high
   io_sync #(
      .sig_t     (logic [2:0]),
      .RESET_VAL (3'b111)
   ) u_status_sync (
      .clk    (clk),
      .arst_n (arst_n),
      .d      ({cx_n, da_n, tbmt_n}),
      .q      ({cx_n_s, da_n_s, tbmt_n_s})
   );

   // INR idles at zero
   io_sync #(
      .sig_t     (nd_io_pkg::idb_byte_t),
      .RESET_VAL ('0)
   ) u_inr_sync (
      .clk    (clk),
      .arst_n (arst_n),
      .d      (inr),
      .q      (inr_s)
   );

   io_read_path #(
      .ALD_SWITCH (ALD_SWITCH),
      .PRINT_NO   (PRINT_NO),
      .STRAPS     (STRAPS)
   ) u_read_path (
      .ald_en_n (traald_n),
      .inr_en_n (rinr_n),
      .cx_n     (cx_n_s),
      .inr      (inr_s),
      .idb_in   (idb_in),
      .idb_out  (idb_out),
      .ioc_d    (ioc_d)                     // Feeds back into the register
   );

   ioc_reg u_ioc_reg (
      .clk       (clk),
      .arst_n    (arst_n),
      .clear_n   (clear_n),
      .sioc_n    (sioc_n),
      .ioc_d     (ioc_d),
      .tbmt_n    (tbmt_n_s),
      .da_n      (da_n_s),
      .bint10_n  (bint10_n),
      .bint12_n  (bint12_n),
      .bint13_n  (bint13_n),
      .console_n (console_n),
      .emcl_n    (emcl_n),
      .io_led    (io_led)
   );

endmodule

`default_nettype wire

// File: tb_io_reg_assertions.sv
// ##########################################################################
// Concurrent checks on io_reg_top outputs, bound into every instance
// Uses only top-level ports; strobes are sampled on the rising clk edge
// Reports through failing assertions only
// ##########################################################################
`default_nettype none

module tb_io_reg_assertions (
   input logic                 clk,
   input logic                 arst_n,
   input logic                 clear_n,
   input logic                 sioc_n,
   input logic                 traald_n,
   input logic                 rinr_n,
   input nd_io_pkg::idb_word_t idb_out,
   input logic                 bint10_n,
   input logic                 bint12_n,
   input logic                 bint13_n
);

   logic seen_write;                        // Any IOC load since reset

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         seen_write <= 1'b0;
      end else if (!sioc_n) begin
         seen_write <= 1'b1;                // Sticky until next reset
      end
   end

   // No strobe, nothing on the bus
   a_idle_bus : assert property (@(posedge clk) disable iff (!arst_n)
      (traald_n && rinr_n) |-> (idb_out == '0))
      else $error("idb_out nonzero with both read strobes high");

   // Clear leaves level 13 and level 10 idle
   a_clear_idle : assert property (@(posedge clk) disable iff (!arst_n)
      !clear_n |=> (bint13_n && bint10_n))
      else $error("interrupt line active right after IOC clear");

   // Zero register after reset keeps all requests off
   a_reset_quiet : assert property (@(posedge clk) disable iff (!arst_n)
      !seen_write |-> (bint10_n && bint12_n && bint13_n))
      else $error("interrupt line active before any IOC write");

endmodule

bind io_reg_top tb_io_reg_assertions u_io_reg_assertions (
   .clk      (clk),
   .arst_n   (arst_n),
   .clear_n  (clear_n),
   .sioc_n   (sioc_n),
   .traald_n (traald_n),
   .rinr_n   (rinr_n),
   .idb_out  (idb_out),
   .bint10_n (bint10_n),
   .bint12_n (bint12_n),
   .bint13_n (bint13_n)
);

`default_nettype wire

// File: tb_io_reg.sv
// ##########################################################################
// Testbench for io_reg_top with its default ALD parameters
// Inputs change 1 unit after the rising edge, outputs checked on the falling
// Each row waits 3 edges for the synchronizers before any strobe
// Run stops at the first mismatch; a watchdog bounds the run time
// ##########################################################################
`default_nettype none

module tb_io_reg;

   // Own copy of the DUT defaults
   localparam logic [3:0] TB_ALD_SWITCH = 4'd5;
   localparam logic [2:0] TB_PRINT_NO   = 3'd3;
   localparam logic [4:0] TB_STRAPS     = 5'b00101;   // Strap 9 down to strap 5

   typedef enum logic [2:0] {
      OP_WRITE,
      OP_READ,
      OP_STATUS,
      OP_CLEAR,
      OP_CLEAR_LOAD                                   // Clear with sioc_n low too
   } op_e;

   typedef struct {
      op_e                  op;
      nd_io_pkg::idb_byte_t din;                      // Byte on idb_in
      logic                 ald_rd_n;
      logic                 inr_rd_n;
      nd_io_pkg::idb_byte_t inr_val;
      logic                 cx_val_n;
      logic                 tbmt_val_n;
      logic                 da_val_n;
      nd_io_pkg::idb_word_t exp_bus;
      logic                 exp_bint10_n;
      logic                 exp_bint12_n;
      logic                 exp_bint13_n;
      logic                 exp_console_n;
      logic                 exp_emcl_n;
      logic [1:0]           exp_led;
   } row_t;

   logic                 clk;
   logic                 arst_n;
   logic                 clear_n;
   logic                 sioc_n;
   logic                 traald_n;
   logic                 rinr_n;
   logic                 cx_n;
   logic                 da_n;
   logic                 tbmt_n;
   nd_io_pkg::idb_byte_t inr;
   nd_io_pkg::idb_byte_t idb_in;
   nd_io_pkg::idb_word_t idb_out;
   logic                 bint10_n;
   logic                 bint12_n;
   logic                 bint13_n;
   logic                 console_n;
   logic                 emcl_n;
   logic [1:0]           io_led;

   row_t                 rows[$];                     // Stimulus table
   nd_io_pkg::idb_byte_t m_ioc;                       // Expected IOC contents
   logic                 table_ready;

   io_reg_top i_io_reg_top (
      .clk       (clk),
      .arst_n    (arst_n),
      .clear_n   (clear_n),
      .sioc_n    (sioc_n),
      .traald_n  (traald_n),
      .rinr_n    (rinr_n),
      .cx_n      (cx_n),
      .da_n      (da_n),
      .tbmt_n    (tbmt_n),
      .inr       (inr),
      .idb_in    (idb_in),
      .idb_out   (idb_out),
      .bint10_n  (bint10_n),
      .bint12_n  (bint12_n),
      .bint13_n  (bint13_n),
      .console_n (console_n),
      .emcl_n    (emcl_n),
      .io_led    (io_led)
   );

   always #5 clk = ~clk;                              // 10 unit period

   // ALD word per the layout, field by field
   function automatic nd_io_pkg::idb_word_t ald_word_of(input logic cx_lvl_n);
      nd_io_pkg::idb_word_t w;
      w        = '0;
      w[3:0]   = TB_ALD_SWITCH;
      w[6:4]   = TB_PRINT_NO;
      w[7]     = cx_lvl_n;
      for (int k = 0; k < 4; k++) begin
         w[8 + k] = TB_STRAPS[4 - k];                 // Strap 9 on bit 8
      end
      w[12]    = TB_STRAPS[0];                        // Strap 5
      w[15:13] = 3'b111;
      return w;
   endfunction

   // Wired-OR of the enabled sources
   function automatic nd_io_pkg::idb_word_t bus_of(input logic ald_rd_n,
                                                   input logic inr_rd_n,
                                                   input nd_io_pkg::idb_byte_t inr_val,
                                                   input logic cx_lvl_n);
      nd_io_pkg::idb_word_t w;
      w = '0;
      if (!ald_rd_n)
         w = ald_word_of(cx_lvl_n);
      if (!inr_rd_n)
         w[7:0] = w[7:0] | inr_val;                   // INR shares the low byte
      return w;
   endfunction

   // Append a row; expected outputs follow the model register
   task automatic add_row(input op_e op, input nd_io_pkg::idb_byte_t din,
                          input logic ald_rd_n, input logic inr_rd_n,
                          input nd_io_pkg::idb_byte_t inr_val, input logic cx_val_n,
                          input logic tbmt_val_n, input logic da_val_n);
      row_t r;
      r.exp_bus = bus_of(ald_rd_n, inr_rd_n, inr_val, cx_val_n);
      case (op)
         OP_WRITE:                m_ioc = din | r.exp_bus[7:0];   // Load sees bus feed
         OP_CLEAR, OP_CLEAR_LOAD: m_ioc = '0;
         default:                 m_ioc = m_ioc;
      endcase
      r.op            = op;
      r.din           = din;
      r.ald_rd_n      = ald_rd_n;
      r.inr_rd_n      = inr_rd_n;
      r.inr_val       = inr_val;
      r.cx_val_n      = cx_val_n;
      r.tbmt_val_n    = tbmt_val_n;
      r.da_val_n      = da_val_n;
      r.exp_bint13_n  = ~(m_ioc[nd_io_pkg::IOC_BIT_IOC3] & m_ioc[nd_io_pkg::IOC_BIT_IOC0]);
      r.exp_bint10_n  = ~(m_ioc[nd_io_pkg::IOC_BIT_IOC2] & ~tbmt_val_n);
      r.exp_bint12_n  = ~(m_ioc[nd_io_pkg::IOC_BIT_SCONS_N] & m_ioc[nd_io_pkg::IOC_BIT_IOC1]
                          & ~da_val_n);
      r.exp_console_n = m_ioc[nd_io_pkg::IOC_BIT_SCONS_N];
      r.exp_emcl_n    = m_ioc[nd_io_pkg::IOC_BIT_RED_N];
      r.exp_led       = {m_ioc[nd_io_pkg::IOC_BIT_GREEN_N], m_ioc[nd_io_pkg::IOC_BIT_RED_N]};
      rows.push_back(r);
   endtask

   task automatic build_table();
      // ALD and INR reads
      add_row(OP_READ, 8'h00, 1'b1, 1'b1, 8'h00, 1'b1, 1'b1, 1'b1);         // Idle bus
      add_row(OP_READ, 8'h00, 1'b0, 1'b1, 8'h00, 1'b1, 1'b1, 1'b1);
      add_row(OP_READ, 8'h00, 1'b0, 1'b1, 8'h00, 1'b0, 1'b1, 1'b1);         // cx_n low
      add_row(OP_READ, 8'h00, 1'b1, 1'b0, 8'hA5, 1'b1, 1'b1, 1'b1);
      add_row(OP_READ, 8'h00, 1'b1, 1'b0, 8'($urandom()), 1'b1, 1'b1, 1'b1);
      add_row(OP_READ, 8'h00, 1'b0, 1'b0, 8'($urandom()), 1'b0, 1'b1, 1'b1);  // Merge
      add_row(OP_READ, 8'h00, 1'b0, 1'b0, 8'h5A, 1'b1, 1'b1, 1'b1);
      // Writes and bus feedback
      add_row(OP_WRITE, 8'h70, 1'b1, 1'b1, 8'h00, 1'b1, 1'b1, 1'b1);        // Lamps off
      add_row(OP_WRITE, 8'h10, 1'b1, 1'b1, 8'h00, 1'b1, 1'b1, 1'b1);
      add_row(OP_WRITE, 8'h08, 1'b0, 1'b1, 8'h00, 1'b1, 1'b1, 1'b1);        // ALD feed
      add_row(OP_WRITE, 8'($urandom()), 1'b1, 1'b0, 8'($urandom()), 1'b1, 1'b1, 1'b1);
      // Interrupt gating
      add_row(OP_WRITE, 8'h4F, 1'b1, 1'b1, 8'h00, 1'b1, 1'b1, 1'b1);
      add_row(OP_STATUS, 8'h00, 1'b1, 1'b1, 8'h00, 1'b1, 1'b1, 1'b1);
      add_row(OP_STATUS, 8'h00, 1'b1, 1'b1, 8'h00, 1'b1, 1'b0, 1'b1);       // TBMT
      add_row(OP_STATUS, 8'h00, 1'b1, 1'b1, 8'h00, 1'b1, 1'b1, 1'b0);       // DA
      add_row(OP_STATUS, 8'h00, 1'b1, 1'b1, 8'h00, 1'b1, 1'b0, 1'b0);
      add_row(OP_WRITE, 8'h0F, 1'b1, 1'b1, 8'h00, 1'b1, 1'b0, 1'b0);        // Console off
      add_row(OP_WRITE, 8'h09, 1'b1, 1'b1, 8'h00, 1'b1, 1'b0, 1'b0);
      // Clear priority
      add_row(OP_WRITE, 8'hFF, 1'b1, 1'b1, 8'h00, 1'b1, 1'b0, 1'b0);
      add_row(OP_CLEAR, 8'h00, 1'b1, 1'b1, 8'h00, 1'b1, 1'b0, 1'b0);
      add_row(OP_WRITE, 8'h7F, 1'b1, 1'b1, 8'h00, 1'b1, 1'b0, 1'b0);
      add_row(OP_CLEAR_LOAD, 8'hFF, 1'b1, 1'b1, 8'h00, 1'b1, 1'b0, 1'b0);   // Clear wins
      add_row(OP_READ, 8'h00, 1'b0, 1'b1, 8'($urandom()), 1'b0, 1'b1, 1'b1);
   endtask

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "Run stopped on first failure");
   endtask

   task automatic check_word(input string name, input nd_io_pkg::idb_word_t expected,
                             input nd_io_pkg::idb_word_t actual);
      if (actual !== expected) begin
         $display("** Error: %s expected 0x%h, got 0x%h", name, expected, actual);
         fail_run("Mismatch on a DUT output");
      end
   endtask

   task automatic check_byte(input string name, input nd_io_pkg::idb_byte_t expected,
                             input nd_io_pkg::idb_byte_t actual);
      if (actual !== expected) begin
         $display("** Error: %s expected 0x%h, got 0x%h", name, expected, actual);
         fail_run("Mismatch on a DUT output");
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("** Error: %s expected 0x%h, got 0x%h", name, expected, actual);
         fail_run("Mismatch on a DUT output");
      end
   endtask

   // Zero register, no read strobe
   task automatic check_reset_state();
      check_word("idb_out", 16'h0000, idb_out);
      check_bit("bint10_n", 1'b1, bint10_n);
      check_bit("bint12_n", 1'b1, bint12_n);
      check_bit("bint13_n", 1'b1, bint13_n);
      check_bit("console_n", 1'b0, console_n);
      check_bit("emcl_n", 1'b0, emcl_n);
      check_bit("io_led[0]", 1'b0, io_led[0]);
      check_bit("io_led[1]", 1'b0, io_led[1]);
   endtask

   task automatic check_row(input row_t r);
      // INR byte first, then the whole word
      if (!r.inr_rd_n)
         check_byte("idb_out[7:0]", r.exp_bus[7:0], idb_out[7:0]);
      check_word("idb_out", r.exp_bus, idb_out);
      check_bit("bint10_n", r.exp_bint10_n, bint10_n);
      check_bit("bint12_n", r.exp_bint12_n, bint12_n);
      check_bit("bint13_n", r.exp_bint13_n, bint13_n);
      check_bit("console_n", r.exp_console_n, console_n);
      check_bit("emcl_n", r.exp_emcl_n, emcl_n);
      check_bit("io_led[0]", r.exp_led[0], io_led[0]);
      check_bit("io_led[1]", r.exp_led[1], io_led[1]);
   endtask

   task automatic apply_row(input row_t r);
      @(posedge clk);
      #1;
      idb_in   = r.din;
      traald_n = r.ald_rd_n;
      rinr_n   = r.inr_rd_n;
      inr      = r.inr_val;
      cx_n     = r.cx_val_n;
      tbmt_n   = r.tbmt_val_n;
      da_n     = r.da_val_n;
      repeat (3) @(posedge clk);                      // Synchronizers settle
      #1;
      if (r.op == OP_WRITE || r.op == OP_CLEAR_LOAD)
         sioc_n = 1'b0;
      if (r.op == OP_CLEAR || r.op == OP_CLEAR_LOAD)
         clear_n = 1'b0;
      @(posedge clk);                                 // Strobe edge
      #1;
      sioc_n  = 1'b1;
      clear_n = 1'b1;
      @(negedge clk);
      check_row(r);
   endtask

   initial begin
      void'($urandom(29));
      clk         = 1'b0;
      arst_n      = 1'b0;
      clear_n     = 1'b1;
      sioc_n      = 1'b1;
      traald_n    = 1'b1;
      rinr_n      = 1'b1;
      cx_n        = 1'b1;
      da_n        = 1'b1;
      tbmt_n      = 1'b1;
      inr         = '0;
      idb_in      = '0;
      m_ioc       = '0;
      table_ready = 1'b0;
      build_table();
      table_ready = 1'b1;
      repeat (8) @(posedge clk);
      #1;
      arst_n = 1'b1;
      @(negedge clk);
      check_reset_state();
      foreach (rows[i]) begin
         apply_row(rows[i]);
      end
      $display("Simulation finished: PASS");
      $finish;
   end

   // Watchdog, 8 cycles per row plus margin
   initial begin
      wait (table_ready === 1'b1);
      #((rows.size() * 8 + 50) * 10);
      fail_run("Timeout: the table did not finish within the expected time");
   end

endmodule

`default_nettype wire

// File: project.f
nd_io_pkg.sv
io_sync.sv
ioc_reg.sv
io_read_path.sv
io_reg_top.sv
tb_io_reg_assertions.sv
tb_io_reg.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
# The exit status is nonzero when the build fails or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_io_reg -f project.f \
   && ./obj_dir/Vtb_io_reg \
   || { echo "Verilator build or simulation failed"; exit 1; }
